//--- filelist.f
design/dma_types_pkg.sv
design/dma_reg_pkg.sv
design/dma_ifs.sv
design/dma_regs.sv
design/dma_control.sv
design/dma_fifo.sv
design/host_stream_out.sv
design/sata_dma_top.sv
testbench/tb_sata_dma_top.sv

//--- Makefile
# Verilator build and run of the sata dma testbench

VERILATOR ?= verilator
TOP       ?= tb_sata_dma_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_sata_dma_top.sv
// sata dma testbench
`timescale 1ns/1ps
`default_nettype none

module tb_sata_dma_top;

    localparam int CLK_NS       = 4;
    localparam int STALL_FACTOR = 8;    // cycles allowed per dword
    localparam int NUM_TESTS    = 6;

    typedef struct packed {
        dma_types_pkg::addr_t base;
        dma_types_pkg::sect_t sectors;
        logic [7:0]           busy_pct;   // host stall chance in percent
    } test_t;

    // low base bits are set on purpose in a few entries
    localparam test_t TESTS [NUM_TESTS] = '{
        '{base: 32'h0000_1000, sectors: 16'd1, busy_pct: 8'd0},
        '{base: 32'h2000_0044, sectors: 16'd2, busy_pct: 8'd30},
        '{base: 32'h0001_0080, sectors: 16'd1, busy_pct: 8'd70},
        '{base: 32'h8000_0000, sectors: 16'd4, busy_pct: 8'd50},
        '{base: 32'h0ff0_007f, sectors: 16'd3, busy_pct: 8'd20},
        '{base: 32'h0000_0000, sectors: 16'd8, busy_pct: 8'd60}
    };

    logic                                 sclk = 1'b0;
    logic                                 arst_n;
    logic                                 reg_wr;
    logic [dma_reg_pkg::REG_AW-1:0]       reg_waddr;
    dma_types_pkg::dword_t                reg_wdata;
    logic                                 reg_rd;
    logic [dma_reg_pkg::REG_AW-1:0]       reg_raddr;
    dma_types_pkg::dword_t                reg_rdata;
    logic                                 mem_req;
    dma_types_pkg::addr_t                 mem_addr;
    logic                                 mem_gnt;
    logic                                 mem_rvalid;
    dma_types_pkg::qword_t                mem_rdata;
    logic                                 out_val;
    dma_types_pkg::dword_t                out_data;
    logic                                 out_busy;

    int                                   seed = 32'h0c79_b1c1;
    int                                   cycle_cnt = 0;
    // memory model state
    dma_types_pkg::addr_t                 burst_q [$];
    int                                   ready_q [$];
    dma_types_pkg::addr_t                 gnt_addr;
    dma_types_pkg::addr_t                 beat_addr;
    int                                   beats_left = 0;
    // host sink state
    int                                   busy_pct = 0;
    dma_types_pkg::addr_t                 exp_base = '0;
    int                                   exp_total = 0;
    int                                   dw_count = 0;
    logic                                 held = 1'b0;
    dma_types_pkg::dword_t                held_data;

    sata_dma_top i_dut (.*);

    always #(CLK_NS / 2) sclk = ~sclk;

    task automatic fail_now();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_stream_dword(input string name, input int idx,
                                       input dma_types_pkg::dword_t got,
                                       input dma_types_pkg::dword_t exp);
        if (got !== exp) begin
            $display("error: %s dword %0d got %h expected %h", name, idx, got, exp);
            fail_now();
        end
    endtask

    task automatic compare_readback(input string name, input dma_types_pkg::dword_t got,
                                    input dma_types_pkg::dword_t exp);
        if (got !== exp) begin
            $display("error: reg_rdata %s got %h expected %h", name, got, exp);
            fail_now();
        end
    endtask

    task automatic verify_status(input dma_types_pkg::dword_t got, input logic busy,
                                 input logic done);
        dma_types_pkg::dword_t exp;
        exp = '0;
        exp[dma_reg_pkg::STAT_BUSY] = busy;
        exp[dma_reg_pkg::STAT_DONE] = done;
        if (got !== exp) begin
            $display("error: reg_rdata status got %h expected %h", got, exp);
            fail_now();
        end
    endtask

    task automatic write_reg(input dma_reg_pkg::reg_addr_e a, input dma_types_pkg::dword_t d);
        @(negedge sclk);
        reg_wr    = 1'b1;
        reg_waddr = a;
        reg_wdata = d;
        @(negedge sclk);
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input dma_reg_pkg::reg_addr_e a, output dma_types_pkg::dword_t v);
        @(negedge sclk);
        reg_rd    = 1'b1;
        reg_raddr = a;
        @(negedge sclk);
        reg_rd = 1'b0;
        v      = reg_rdata;    // registered the edge before
    endtask

    // grants requests at random, returns 16 words per burst after a random latency
    task automatic memory_step();
        int unsigned r;
        if (mem_gnt) begin  // taken at the rising edge just passed
            r = $random(seed);
            burst_q.push_back(gnt_addr);
            ready_q.push_back(cycle_cnt + 3 + int'(r % 6));
        end
        mem_gnt = 1'b0;
        if (mem_req) begin
            r        = $random(seed);
            mem_gnt  = r[0];
            gnt_addr = mem_addr;
        end
        mem_rvalid = 1'b0;
        if (beats_left == 0 && burst_q.size() != 0 && cycle_cnt >= ready_q[0]) begin
            beat_addr  = burst_q.pop_front();
            void'(ready_q.pop_front());
            beats_left = dma_types_pkg::BURST_QWORDS;
        end
        if (beats_left != 0) begin
            mem_rvalid = 1'b1;
            mem_rdata  = {beat_addr, ~beat_addr};   // address high, inverse low
            beat_addr  = beat_addr + 32'd8;
            beats_left--;
        end
    endtask

    task automatic host_step();
        int unsigned           r;
        dma_types_pkg::addr_t  a;
        dma_types_pkg::dword_t exp;
        if (held) begin
            if (!out_val) begin
                $display("error: out_val dropped while the host was stalling");
                fail_now();
            end
            expect_stream_dword("out_data held", dw_count, out_data, held_data);
        end
        r         = $random(seed);
        out_busy  = (r % 100) < busy_pct;
        held      = out_val && out_busy;
        held_data = out_data;
        if (out_val && !out_busy) begin
            if (dw_count >= exp_total) begin
                $display("error: dword offered beyond the %0d of the transfer", exp_total);
                fail_now();
            end
            a   = exp_base + 32'(8 * (dw_count / 2));
            exp = dw_count[0] ? a : ~a;
            expect_stream_dword("out_data", dw_count, out_data, exp);
            dw_count++;
        end
    endtask

    always @(negedge sclk) begin
        if (arst_n) begin
            cycle_cnt++;
            memory_step();
            host_step();
        end
    end

    initial begin : watchdog
        longint limit;
        limit = NUM_TESTS * 300;
        for (int t = 0; t < NUM_TESTS; t++)
            limit += longint'(TESTS[t].sectors) * 128 * STALL_FACTOR;
        #(limit * CLK_NS);
        $display("timeout: transfers still running after %0d cycles", limit);
        fail_now();
    end

    initial begin : main
        dma_types_pkg::dword_t v;
        arst_n     = 1'b0;
        reg_wr     = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_rd     = 1'b0;
        reg_raddr  = '0;
        mem_gnt    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        out_busy   = 1'b0;
        repeat (2) @(negedge sclk);
        arst_n = 1'b1;

        if (mem_req !== 1'b0 || out_val !== 1'b0) begin
            $display("error: mem_req %h out_val %h after reset expected 0", mem_req, out_val);
            fail_now();
        end
        read_reg(dma_reg_pkg::reg_status, v);
        verify_status(v, 1'b0, 1'b0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            write_reg(dma_reg_pkg::reg_addr, TESTS[t].base);
            write_reg(dma_reg_pkg::reg_sectors, 32'(TESTS[t].sectors));
            read_reg(dma_reg_pkg::reg_addr, v);
            compare_readback("base", v, TESTS[t].base & ~32'h7f);
            read_reg(dma_reg_pkg::reg_sectors, v);
            compare_readback("sectors", v, 32'(TESTS[t].sectors));

            busy_pct  = int'(TESTS[t].busy_pct);
            exp_base  = TESTS[t].base & ~32'h7f;
            exp_total = int'(TESTS[t].sectors) * 128;
            dw_count  = 0;
            write_reg(dma_reg_pkg::reg_ctrl, 32'h1);
            read_reg(dma_reg_pkg::reg_status, v);
            verify_status(v, 1'b1, 1'b0);   // running, old done cleared

            while (dw_count < exp_total)
                @(negedge sclk);
            do
                read_reg(dma_reg_pkg::reg_status, v);
            while (!v[dma_reg_pkg::STAT_DONE]);
            verify_status(v, 1'b0, 1'b1);
            if (out_val || burst_q.size() != 0 || beats_left != 0) begin
                $display("error: data or bursts left over after test %0d finished", t);
                fail_now();
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/sata_dma_top.sv
// sata sector dma top
`timescale 1ns/1ps
`default_nettype none

module sata_dma_top (
    input  wire                             sclk,
    input  wire                             arst_n,
    // register port
    input  wire                             reg_wr,
    input  wire [dma_reg_pkg::REG_AW-1:0]   reg_waddr,
    input  wire dma_types_pkg::dword_t      reg_wdata,
    input  wire                             reg_rd,
    input  wire [dma_reg_pkg::REG_AW-1:0]   reg_raddr,
    output dma_types_pkg::dword_t           reg_rdata,
    // memory burst read port
    output logic                            mem_req,
    output dma_types_pkg::addr_t            mem_addr,
    input  wire                             mem_gnt,
    input  wire                             mem_rvalid,
    input  wire dma_types_pkg::qword_t      mem_rdata,
    // host data out
    output logic                            out_val,
    output dma_types_pkg::dword_t           out_data,
    input  wire                             out_busy
);

    dma_cmd_if cmd_if ();
    fifo_wr_if wr_if ();
    fifo_rd_if rd_if ();

    dma_regs dma_regs (
        .sclk       (sclk),
        .arst_n     (arst_n),
        .reg_wr     (reg_wr),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_rd     (reg_rd),
        .reg_raddr  (reg_raddr),
        .reg_rdata  (reg_rdata),
        .cmd        (cmd_if.regs)
    );

    dma_control dma_control (
        .sclk       (sclk),
        .arst_n     (arst_n),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_gnt    (mem_gnt),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .cmd        (cmd_if.ctrl),
        .wr         (wr_if.src)
    );

    dma_fifo dma_fifo (
        .sclk       (sclk),
        .arst_n     (arst_n),
        .wr         (wr_if.sink),
        .rd         (rd_if.src)
    );

    host_stream_out host_stream_out (
        .sclk       (sclk),
        .arst_n     (arst_n),
        .out_val    (out_val),
        .out_data   (out_data),
        .out_busy   (out_busy),
        .rd         (rd_if.sink),
        .cmd        (cmd_if.stream)
    );

endmodule

`default_nettype wire

//--- design/host_stream_out.sv
// host side dword stream
`timescale 1ns/1ps
`default_nettype none

module host_stream_out (
    input  wire                     sclk,
    input  wire                     arst_n,
    output logic                    out_val,
    output dma_types_pkg::dword_t   out_data,
    input  wire                     out_busy,
    fifo_rd_if.sink                 rd,
    dma_cmd_if.stream               cmd
);

    logic hi_half;  // 0 shows bits 31:0
    logic taken;

    assign out_val  = rd.valid;
    assign out_data = hi_half ? rd.data[dma_types_pkg::QWORD_W-1:dma_types_pkg::DWORD_W]
                              : rd.data[dma_types_pkg::DWORD_W-1:0];
    assign taken    = out_val && !out_busy;

    // entry leaves with its high dword
    assign rd.pop   = taken && hi_half;
    assign cmd.done = rd.pop && rd.last;

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n)
            hi_half <= 1'b0;
        else if (taken)
            hi_half <= !hi_half;
    end

    // host stall must freeze the offered dword
    assert property (@(posedge sclk) disable iff (!arst_n)
        out_val && out_busy |=> out_val && $stable(out_data));

endmodule

`default_nettype wire

//--- design/dma_fifo.sv
// qword buffer between memory and host
`timescale 1ns/1ps
`default_nettype none

module dma_fifo (
    input  wire     sclk,
    input  wire     arst_n,
    fifo_wr_if.sink wr,
    fifo_rd_if.src  rd
);

    // each entry is {last, data}
    logic [dma_types_pkg::QWORD_W:0]        mem [dma_types_pkg::FIFO_DEPTH];
    logic [dma_types_pkg::FIFO_CNT_W-2:0]   wr_ptr;
    logic [dma_types_pkg::FIFO_CNT_W-2:0]   rd_ptr;
    logic [dma_types_pkg::FIFO_CNT_W-1:0]   count;
    logic                                   do_pop;

    assign do_pop = rd.valid && rd.pop;

    always_ff @(posedge sclk) begin
        if (wr.push)
            mem[wr_ptr] <= {wr.last, wr.data};
    end

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr.push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr.push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign rd.valid           = count != 0;
    assign {rd.last, rd.data} = mem[rd_ptr];
    assign wr.free = (dma_types_pkg::FIFO_CNT_W)'(dma_types_pkg::FIFO_DEPTH) - count;

    // a push into a full buffer only survives if the head leaves at the same edge
    assert property (@(posedge sclk) disable iff (!arst_n)
        (count == dma_types_pkg::FIFO_DEPTH) && wr.push |-> do_pop);

endmodule

`default_nettype wire

//--- design/dma_control.sv
// memory burst read control
`timescale 1ns/1ps
`default_nettype none

module dma_control (
    input  wire                         sclk,
    input  wire                         arst_n,
    output logic                        mem_req,
    output dma_types_pkg::addr_t        mem_addr,
    input  wire                         mem_gnt,
    input  wire                         mem_rvalid,
    input  wire dma_types_pkg::qword_t  mem_rdata,
    dma_cmd_if.ctrl                     cmd,
    fifo_wr_if.src                      wr
);

    dma_types_pkg::ctrl_state_e             state;
    dma_types_pkg::burst_addr_t             req_addr;
    logic [dma_types_pkg::SECT_W+1:0]       bursts_left;    // sectors * 4
    logic [dma_types_pkg::SECT_W+5:0]       words_left;     // sectors * 64
    logic [dma_types_pkg::FIFO_CNT_W-1:0]   reserved;       // words owed by accepted bursts
    logic                                   grant;
    logic                                   launch;
    logic                                   credit_ok;
    logic                                   push_q;
    logic                                   last_q;
    dma_types_pkg::qword_t                  data_q;

    assign grant  = mem_req && mem_gnt;
    assign launch = (state == dma_types_pkg::ctrl_idle) && cmd.start;
    assign credit_ok = (wr.free - reserved) >=
                       (dma_types_pkg::FIFO_CNT_W)'(dma_types_pkg::BURST_QWORDS);

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= dma_types_pkg::ctrl_idle;
            mem_req     <= 1'b0;
            bursts_left <= '0;
            reserved    <= '0;
            cmd.busy    <= 1'b0;
        end else begin
            reserved <= reserved
                      + (grant ? (dma_types_pkg::FIFO_CNT_W)'(dma_types_pkg::BURST_QWORDS) : '0)
                      - (dma_types_pkg::FIFO_CNT_W)'(wr.push);
            if (cmd.start)
                cmd.busy <= 1'b1;
            else if (cmd.done)
                cmd.busy <= 1'b0;
            case (state)
                dma_types_pkg::ctrl_idle: if (launch) begin
                    bursts_left <= (dma_types_pkg::SECT_W + 2)'(cmd.sectors *
                                   dma_types_pkg::SECTOR_BURSTS);
                    state       <= dma_types_pkg::ctrl_request;
                end
                dma_types_pkg::ctrl_request: begin
                    // drop req for a cycle after grant so reserved catches up
                    if (grant) begin
                        mem_req     <= 1'b0;
                        bursts_left <= bursts_left - 1'b1;
                        if (bursts_left == 1)
                            state <= dma_types_pkg::ctrl_drain;
                    end else if (!mem_req && credit_ok) begin
                        mem_req <= 1'b1;
                    end
                end
                dma_types_pkg::ctrl_drain: if (wr.push && wr.last)
                    state <= dma_types_pkg::ctrl_idle;
                default: state <= dma_types_pkg::ctrl_idle;
            endcase
        end
    end

    always_ff @(posedge sclk) begin
        if (launch)
            req_addr <= cmd.base;
        else if (grant)
            req_addr <= req_addr + 1'b1;    // next 128 byte burst
        if (mem_rvalid)
            data_q <= mem_rdata;
    end

    // return path, one register stage into the buffer
    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            push_q     <= 1'b0;
            last_q     <= 1'b0;
            words_left <= '0;
        end else begin
            push_q <= mem_rvalid;
            last_q <= mem_rvalid && (words_left == 1);
            if (launch)
                words_left <= (dma_types_pkg::SECT_W + 6)'(cmd.sectors *
                              dma_types_pkg::SECTOR_BURSTS * dma_types_pkg::BURST_QWORDS);
            else if (mem_rvalid)
                words_left <= words_left - 1'b1;
        end
    end

    assign mem_addr = {req_addr, {dma_types_pkg::BURST_ALIGN{1'b0}}};
    assign wr.push  = push_q;
    assign wr.data  = data_q;
    assign wr.last  = last_q;

    assert property (@(posedge sclk) disable iff (!arst_n)
        mem_req && !mem_gnt |=> mem_req && $stable(mem_addr));
    assert property (@(posedge sclk) disable iff (!arst_n) wr.push |-> wr.free != 0);

endmodule

`default_nettype wire

//--- design/dma_regs.sv
// dma programmable registers
`timescale 1ns/1ps
`default_nettype none

module dma_regs (
    input  wire                             sclk,
    input  wire                             arst_n,
    input  wire                             reg_wr,
    input  wire [dma_reg_pkg::REG_AW-1:0]   reg_waddr,
    input  wire dma_types_pkg::dword_t      reg_wdata,
    input  wire                             reg_rd,
    input  wire [dma_reg_pkg::REG_AW-1:0]   reg_raddr,
    output dma_types_pkg::dword_t           reg_rdata,
    dma_cmd_if.regs                         cmd
);

    logic                       wr_base;
    logic                       wr_sectors;
    logic                       wr_start;
    logic                       cfg_open;   // no transfer pending or running
    logic                       start_q;
    logic                       done_q;     // sticky
    dma_types_pkg::burst_addr_t base_q;
    dma_types_pkg::sect_t       sectors_q;
    dma_types_pkg::dword_t      status;

    assign cfg_open = !cmd.busy && !start_q;

    always_comb begin
        wr_base    = 1'b0;
        wr_sectors = 1'b0;
        wr_start   = 1'b0;
        if (reg_wr) begin
            case (dma_reg_pkg::reg_addr_e'(reg_waddr))
                dma_reg_pkg::reg_addr:    wr_base    = 1'b1;
                dma_reg_pkg::reg_sectors: wr_sectors = 1'b1;
                dma_reg_pkg::reg_ctrl:    wr_start   = reg_wdata[0];
                default: ;                // status is read only
            endcase
        end
    end

    always_comb begin
        status = '0;
        status[dma_reg_pkg::STAT_BUSY] = cmd.busy;
        status[dma_reg_pkg::STAT_DONE] = done_q;
    end

    // base and count frozen while a transfer runs
    always_ff @(posedge sclk) begin
        if (wr_base && cfg_open)
            base_q <= reg_wdata[dma_types_pkg::ADDR_W-1:dma_types_pkg::BURST_ALIGN];
        if (wr_sectors && cfg_open)
            sectors_q <= reg_wdata[dma_types_pkg::SECT_W-1:0];
    end

    always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
            start_q   <= 1'b0;
            done_q    <= 1'b0;
            reg_rdata <= '0;
        end else begin
            start_q <= wr_start && cfg_open;
            if (start_q)
                done_q <= 1'b0;
            else if (cmd.done)
                done_q <= 1'b1;
            if (reg_rd) begin
                case (dma_reg_pkg::reg_addr_e'(reg_raddr))
                    dma_reg_pkg::reg_addr:
                        reg_rdata <= {base_q, {dma_types_pkg::BURST_ALIGN{1'b0}}};
                    dma_reg_pkg::reg_sectors:
                        reg_rdata <= {{(dma_types_pkg::DWORD_W - dma_types_pkg::SECT_W){1'b0}},
                                      sectors_q};
                    dma_reg_pkg::reg_status: reg_rdata <= status;
                    default:                 reg_rdata <= '0;  // ctrl reads zero
                endcase
            end
        end
    end

    assign cmd.start   = start_q;
    assign cmd.base    = base_q;
    assign cmd.sectors = sectors_q;

    // busy comes back from the control one cycle after start
    assert property (@(posedge sclk) disable iff (!arst_n) cmd.start |-> !cmd.busy);

endmodule

`default_nettype wire

//--- design/dma_ifs.sv
// dma internal links
`timescale 1ns/1ps
`default_nettype none

// command and completion between registers, control and stream
interface dma_cmd_if;
    logic                       start;      // one cycle pulse
    dma_types_pkg::burst_addr_t base;
    dma_types_pkg::sect_t       sectors;
    logic                       busy;
    logic                       done;       // last dword taken

    modport regs   (output start, base, sectors, input busy, done);
    modport ctrl   (input start, base, sectors, done, output busy);
    modport stream (output done);
endinterface

// write side of the word buffer
interface fifo_wr_if;
    logic                                   push;
    dma_types_pkg::qword_t                  data;
    logic                                   last;   // final word of the transfer
    logic [dma_types_pkg::FIFO_CNT_W-1:0]   free;

    modport src  (output push, data, last, input free);
    modport sink (input push, data, last, output free);
endinterface

// read side of the word buffer, head entry shown
interface fifo_rd_if;
    logic                   valid;
    dma_types_pkg::qword_t  data;
    logic                   last;
    logic                   pop;

    modport src  (output valid, data, last, input pop);
    modport sink (input valid, data, last, output pop);
endinterface

`default_nettype wire

//--- design/dma_reg_pkg.sv
// dma register map
`default_nettype none

package dma_reg_pkg;

    localparam int REG_AW = 2;  // word address

    typedef enum logic [REG_AW-1:0] {
        reg_addr    = 2'd0,     // base address, burst aligned
        reg_sectors = 2'd1,     // sector count
        reg_ctrl    = 2'd2,     // bit 0 starts a transfer
        reg_status  = 2'd3
    } reg_addr_e;

    // status word bits
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;   // sticky until next start

endpackage

`default_nettype wire

//--- design/dma_types_pkg.sv
// dma data path types
`default_nettype none

package dma_types_pkg;

    localparam int QWORD_W       = 64;  // memory side word
    localparam int DWORD_W       = 32;  // host side dword
    localparam int ADDR_W        = 32;  // byte address
    localparam int BURST_QWORDS  = 16;
    localparam int BURST_ALIGN   = 7;   // 128 byte bursts
    localparam int SECTOR_BURSTS = 4;   // 512 byte sector
    localparam int SECT_W        = 16;
    localparam int FIFO_DEPTH    = 64;
    localparam int FIFO_CNT_W    = 7;   // holds 0 .. FIFO_DEPTH

    typedef logic [QWORD_W-1:0]            qword_t;
    typedef logic [DWORD_W-1:0]            dword_t;
    typedef logic [ADDR_W-1:0]             addr_t;
    typedef logic [SECT_W-1:0]             sect_t;
    typedef logic [ADDR_W-BURST_ALIGN-1:0] burst_addr_t;

    // memory read side of the engine
    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_request,   // issuing bursts
        ctrl_drain      // waiting for the final returns
    } ctrl_state_e;

endpackage

`default_nettype wire
